//--- verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // data or address word
    typedef logic [31:0] word_t;

    // general register index
    typedef logic [4:0] reg_idx_t;

    // csr number as encoded in the instruction
    typedef logic [13:0] csr_num_t;

    // exception code as written to estat
    typedef logic [5:0] ecode_t;

endpackage

`default_nettype wire

//--- verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // memory / csr operation codes from decode
    typedef logic [3:0] mem_op_t;

    localparam mem_op_t op_none  = 4'd0;
    localparam mem_op_t op_ld_b  = 4'd1;
    localparam mem_op_t op_ld_h  = 4'd2;
    localparam mem_op_t op_ld_w  = 4'd3;
    localparam mem_op_t op_ld_bu = 4'd4;
    localparam mem_op_t op_ld_hu = 4'd5;
    localparam mem_op_t op_st_b  = 4'd6;
    localparam mem_op_t op_st_h  = 4'd7;
    localparam mem_op_t op_st_w  = 4'd8;
    localparam mem_op_t op_csrwr = 4'd9;

    // csrs whose write changes translation or privilege, so refetch
    localparam logic [13:0] csr_crmd = 14'h0;
    localparam logic [13:0] csr_asid = 14'h18;
    localparam logic [13:0] csr_dmw0 = 14'h180;
    localparam logic [13:0] csr_dmw1 = 14'h181;

    // exception codes
    localparam logic [5:0] ecode_none = 6'h0;
    localparam logic [5:0] ecode_ale  = 6'h9;   // address alignment error

    // fixed exception vector
    localparam logic [31:0] excep_entry = 32'h1c00_8000;

endpackage

`default_nettype wire

//--- verilog/ex_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ex_mem_if
    import pipe_pkg::*, isa_pkg::*;
();
    logic       valid;
    word_t      pc;
    mem_op_t    op;
    reg_idx_t   rd;
    logic [1:0] addr_lo;      // low address bits for lane select
    word_t      alu_result;   // address, or csr write data
    csr_num_t   csr_num;
    logic       excep;
    ecode_t     ecode;
    word_t      badv;
    logic       requested;    // sram request went out with this item
    logic       allowin;
    logic       cancel;       // excep/refetch sitting in mem

    modport ex (
        output valid, pc, op, rd, addr_lo, alu_result, csr_num,
        output excep, ecode, badv, requested,
        input  allowin, cancel
    );

    modport mem (
        input  valid, pc, op, rd, addr_lo, alu_result, csr_num,
        input  excep, ecode, badv, requested,
        output allowin, cancel
    );

endinterface

`default_nettype wire

//--- verilog/mem_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_wb_if
    import pipe_pkg::*;
();
    logic     valid;
    word_t    pc;
    logic     rf_we;
    reg_idx_t rd;
    word_t    rf_wdata;
    logic     csr_we;
    csr_num_t csr_num;
    word_t    csr_wdata;
    logic     excep;
    ecode_t   ecode;
    word_t    badv;
    logic     refetch;   // csr write needs the pipe restarted
    logic     allowin;

    modport mem (
        output valid, pc, rf_we, rd, rf_wdata, csr_we, csr_num, csr_wdata,
        output excep, ecode, badv, refetch,
        input  allowin
    );

    modport wb (
        input  valid, pc, rf_we, rd, rf_wdata, csr_we, csr_num, csr_wdata,
        input  excep, ecode, badv, refetch,
        output allowin
    );

endinterface

`default_nettype wire

//--- verilog/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import pipe_pkg::*, isa_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       flush,
    input  logic       in_valid,
    output logic       in_allowin,
    input  word_t      in_pc,
    input  mem_op_t    in_op,
    input  reg_idx_t   in_rd,
    input  word_t      in_base,
    input  word_t      in_offset,
    input  word_t      in_rkd,
    output logic       data_sram_req,
    output logic       data_sram_wr,
    output logic [3:0] data_sram_wstrb,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    ex_mem_if.ex       ex_mem
);

    logic     ex_valid;
    word_t    ex_pc;
    mem_op_t  ex_op;
    reg_idx_t ex_rd;
    word_t    ex_base;
    word_t    ex_offset;
    word_t    ex_rkd;
    logic     ex_ready_go;
    word_t    ex_addr;
    logic     is_load;
    logic     is_store;
    logic     is_half;
    logic     is_word;
    logic     ale;

    // hold while an older excep/refetch is in mem; flush removes us next
    assign ex_ready_go = ~ex_mem.cancel;
    // no item taken in the flush cycle as it would be dropped anyway
    assign in_allowin  = (~ex_valid | ex_ready_go & ex_mem.allowin) & ~flush;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (in_allowin) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            ex_pc     <= in_pc;
            ex_op     <= in_op;
            ex_rd     <= in_rd;
            ex_base   <= in_base;
            ex_offset <= in_offset;
            ex_rkd    <= in_rkd;
        end
    end

    assign ex_addr  = ex_base + ex_offset;
    assign is_load  = (ex_op == op_ld_b) || (ex_op == op_ld_h) || (ex_op == op_ld_w)
                    || (ex_op == op_ld_bu) || (ex_op == op_ld_hu);
    assign is_store = (ex_op == op_st_b) || (ex_op == op_st_h) || (ex_op == op_st_w);
    assign is_half  = (ex_op == op_ld_h) || (ex_op == op_ld_hu) || (ex_op == op_st_h);
    assign is_word  = (ex_op == op_ld_w) || (ex_op == op_st_w);
    assign ale      = is_half & ex_addr[0] | is_word & (|ex_addr[1:0]);

    // goes out the same cycle the item moves into mem
    assign data_sram_req  = ex_valid & (is_load | is_store) & ~ale & ~ex_mem.cancel
                          & ~flush & ex_mem.allowin;
    assign data_sram_wr   = is_store;
    assign data_sram_addr = ex_addr;

    always_comb begin
        case (ex_op)
            op_st_b: begin
                data_sram_wdata = {4{ex_rkd[7:0]}};
                data_sram_wstrb = 4'b0001 << ex_addr[1:0];
            end
            op_st_h: begin
                data_sram_wdata = {2{ex_rkd[15:0]}};
                data_sram_wstrb = ex_addr[1] ? 4'b1100 : 4'b0011;
            end
            op_st_w: begin
                data_sram_wdata = ex_rkd;
                data_sram_wstrb = 4'b1111;
            end
            default: begin
                data_sram_wdata = ex_rkd;
                data_sram_wstrb = 4'b0000;   // loads touch no bytes
            end
        endcase
    end

    assign ex_mem.valid      = ex_valid & ex_ready_go & ~flush;
    assign ex_mem.pc         = ex_pc;
    assign ex_mem.op         = ex_op;
    assign ex_mem.rd         = ex_rd;
    assign ex_mem.addr_lo    = ex_addr[1:0];
    assign ex_mem.alu_result = (ex_op == op_csrwr) ? ex_rkd : ex_addr;
    assign ex_mem.csr_num    = ex_offset[13:0];   // csr field rides in the offset
    assign ex_mem.excep      = ale;
    assign ex_mem.ecode      = ale ? ecode_ale : ecode_none;
    assign ex_mem.badv       = ex_addr;
    assign ex_mem.requested  = data_sram_req;

    // the op held behind a cancel is flushed before it can reach memory
    a_flush_follows_cancel: assert property (
        @(posedge clk) disable iff (!resetn) ex_mem.cancel |=> flush
    );

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import pipe_pkg::*, isa_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  flush,
    input  logic  data_sram_data_ok,
    input  word_t data_sram_rdata,
    ex_mem_if.mem ex_mem,
    mem_wb_if.mem mem_wb
);

    typedef enum logic [0:0] {
        idle,
        wait_data
    } mem_wait_e;

    mem_wait_e  state;
    logic       mem_valid;
    word_t      mem_pc;
    mem_op_t    mem_op;
    reg_idx_t   mem_rd;
    logic [1:0] mem_addr_lo;
    word_t      mem_alu_result;
    csr_num_t   mem_csr_num;
    logic       mem_excep;
    ecode_t     mem_ecode;
    word_t      mem_badv;
    logic       mem_ready_go;
    logic       mem_accept;
    logic       is_load;
    logic       is_byte;
    logic       is_half;
    logic       is_unsigned;
    logic       csr_we;
    logic       refetch;
    logic [7:0] byte_lane;
    logic [15:0] half_lane;
    word_t      load_result;

    // no request means nothing to wait for
    assign mem_ready_go   = (state == idle) | data_sram_data_ok;
    assign ex_mem.allowin = ~mem_valid | mem_ready_go & mem_wb.allowin;
    assign mem_accept     = ex_mem.valid & ex_mem.allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (flush) begin
            mem_valid <= 1'b0;
        end else if (ex_mem.allowin) begin
            mem_valid <= ex_mem.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_accept) begin
            mem_pc         <= ex_mem.pc;
            mem_op         <= ex_mem.op;
            mem_rd         <= ex_mem.rd;
            mem_addr_lo    <= ex_mem.addr_lo;
            mem_alu_result <= ex_mem.alu_result;
            mem_csr_num    <= ex_mem.csr_num;
            mem_excep      <= ex_mem.excep;
            mem_ecode      <= ex_mem.ecode;
            mem_badv       <= ex_mem.badv;
        end
    end

    // outstanding-response tracker
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= idle;
        end else if (mem_accept) begin
            state <= ex_mem.requested ? wait_data : idle;   // old item left this edge
        end else if (data_sram_data_ok) begin
            state <= idle;
        end
    end

    assign is_byte     = (mem_op == op_ld_b) || (mem_op == op_ld_bu);
    assign is_half     = (mem_op == op_ld_h) || (mem_op == op_ld_hu);
    assign is_unsigned = (mem_op == op_ld_bu) || (mem_op == op_ld_hu);
    assign is_load     = is_byte | is_half | (mem_op == op_ld_w);
    assign csr_we      = (mem_op == op_csrwr);

    always_comb begin
        case (mem_addr_lo)
            2'd0:    byte_lane = data_sram_rdata[7:0];
            2'd1:    byte_lane = data_sram_rdata[15:8];
            2'd2:    byte_lane = data_sram_rdata[23:16];
            default: byte_lane = data_sram_rdata[31:24];
        endcase
    end

    assign half_lane = mem_addr_lo[1] ? data_sram_rdata[31:16] : data_sram_rdata[15:0];

    always_comb begin
        if (is_byte) begin
            load_result = {{24{~is_unsigned & byte_lane[7]}}, byte_lane};
        end else if (is_half) begin
            load_result = {{16{~is_unsigned & half_lane[15]}}, half_lane};
        end else begin
            load_result = data_sram_rdata;
        end
    end

    assign refetch = csr_we && (mem_csr_num == csr_crmd || mem_csr_num == csr_asid
                             || mem_csr_num == csr_dmw0 || mem_csr_num == csr_dmw1);

    assign ex_mem.cancel = mem_valid & (mem_excep | refetch);

    assign mem_wb.valid     = mem_valid & mem_ready_go & ~flush;
    assign mem_wb.pc        = mem_pc;
    assign mem_wb.rf_we     = is_load;
    assign mem_wb.rd        = mem_rd;
    assign mem_wb.rf_wdata  = is_load ? load_result : mem_alu_result;
    assign mem_wb.csr_we    = csr_we;
    assign mem_wb.csr_num   = mem_csr_num;
    assign mem_wb.csr_wdata = mem_alu_result;
    assign mem_wb.excep     = mem_excep;
    assign mem_wb.ecode     = mem_ecode;
    assign mem_wb.badv      = mem_badv;
    assign mem_wb.refetch   = refetch;

    // sram may only answer a request that ex actually issued
    a_data_ok_in_wait: assert property (
        @(posedge clk) disable iff (!resetn) data_sram_data_ok |-> state == wait_data
    );

endmodule

`default_nettype wire

//--- verilog/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage
    import pipe_pkg::*, isa_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    mem_wb_if.wb     mem_wb,
    output logic     flush,
    output word_t    flush_pc,
    output logic     retire_valid,
    output word_t    retire_pc,
    output logic     retire_rf_we,
    output reg_idx_t retire_rd,
    output word_t    retire_rf_wdata,
    output logic     retire_csr_we,
    output csr_num_t retire_csr_num,
    output word_t    retire_csr_wdata,
    output logic     retire_excep,
    output ecode_t   retire_ecode,
    output word_t    retire_badv
);

    logic     wb_valid;
    word_t    wb_pc;
    logic     wb_rf_we;
    reg_idx_t wb_rd;
    word_t    wb_rf_wdata;
    logic     wb_csr_we;
    csr_num_t wb_csr_num;
    word_t    wb_csr_wdata;
    logic     wb_excep;
    ecode_t   wb_ecode;
    word_t    wb_badv;
    logic     wb_refetch;

    assign mem_wb.allowin = 1'b1;   // retire never stalls

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_wb.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wb.valid) begin
            wb_pc        <= mem_wb.pc;
            wb_rf_we     <= mem_wb.rf_we;
            wb_rd        <= mem_wb.rd;
            wb_rf_wdata  <= mem_wb.rf_wdata;
            wb_csr_we    <= mem_wb.csr_we;
            wb_csr_num   <= mem_wb.csr_num;
            wb_csr_wdata <= mem_wb.csr_wdata;
            wb_excep     <= mem_wb.excep;
            wb_ecode     <= mem_wb.ecode;
            wb_badv      <= mem_wb.badv;
            wb_refetch   <= mem_wb.refetch;
        end
    end

    // early enough to block the next sram request in ex
    assign flush    = wb_valid & (wb_excep | wb_refetch);
    assign flush_pc = wb_excep ? excep_entry : wb_pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        retire_pc        <= wb_pc;
        retire_rf_we     <= wb_rf_we & ~wb_excep;    // excepting op commits nothing
        retire_rd        <= wb_rd;
        retire_rf_wdata  <= wb_rf_wdata;
        retire_csr_we    <= wb_csr_we & ~wb_excep;
        retire_csr_num   <= wb_csr_num;
        retire_csr_wdata <= wb_csr_wdata;
        retire_excep     <= wb_excep;
        retire_ecode     <= wb_ecode;
        retire_badv      <= wb_badv;
    end

endmodule

`default_nettype wire

//--- verilog/mem_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_top
    import pipe_pkg::*, isa_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       in_valid,
    output logic       in_allowin,
    input  word_t      in_pc,
    input  mem_op_t    in_op,
    input  reg_idx_t   in_rd,
    input  word_t      in_base,
    input  word_t      in_offset,
    input  word_t      in_rkd,
    output logic       data_sram_req,
    output logic       data_sram_wr,
    output logic [3:0] data_sram_wstrb,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  logic       data_sram_data_ok,
    input  word_t      data_sram_rdata,
    output logic       flush,
    output word_t      flush_pc,
    output logic       retire_valid,
    output word_t      retire_pc,
    output logic       retire_rf_we,
    output reg_idx_t   retire_rd,
    output word_t      retire_rf_wdata,
    output logic       retire_csr_we,
    output csr_num_t   retire_csr_num,
    output word_t      retire_csr_wdata,
    output logic       retire_excep,
    output ecode_t     retire_ecode,
    output word_t      retire_badv
);

    ex_mem_if ex_mem_bus ();
    mem_wb_if mem_wb_bus ();

    ex_stage u_ex (
        .clk             (clk),
        .resetn          (resetn),
        .flush           (flush),
        .in_valid        (in_valid),
        .in_allowin      (in_allowin),
        .in_pc           (in_pc),
        .in_op           (in_op),
        .in_rd           (in_rd),
        .in_base         (in_base),
        .in_offset       (in_offset),
        .in_rkd          (in_rkd),
        .data_sram_req   (data_sram_req),
        .data_sram_wr    (data_sram_wr),
        .data_sram_wstrb (data_sram_wstrb),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .ex_mem          (ex_mem_bus)
    );

    mem_stage u_mem (
        .clk               (clk),
        .resetn            (resetn),
        .flush             (flush),
        .data_sram_data_ok (data_sram_data_ok),
        .data_sram_rdata   (data_sram_rdata),
        .ex_mem            (ex_mem_bus),
        .mem_wb            (mem_wb_bus)
    );

    wb_stage u_wb (
        .clk              (clk),
        .resetn           (resetn),
        .mem_wb           (mem_wb_bus),
        .flush            (flush),
        .flush_pc         (flush_pc),
        .retire_valid     (retire_valid),
        .retire_pc        (retire_pc),
        .retire_rf_we     (retire_rf_we),
        .retire_rd        (retire_rd),
        .retire_rf_wdata  (retire_rf_wdata),
        .retire_csr_we    (retire_csr_we),
        .retire_csr_num   (retire_csr_num),
        .retire_csr_wdata (retire_csr_wdata),
        .retire_excep     (retire_excep),
        .retire_ecode     (retire_ecode),
        .retire_badv      (retire_badv)
    );

endmodule

`default_nettype wire

//--- verif/tb_mem_tests.svh
// expected load result from the predicted memory
function automatic word_t ref_load(input mem_op_t op, input word_t addr);
    word_t sh;
    sh = ref_mem[addr[7:2]] >> {addr[1:0], 3'b000};   // wanted lane moved to bit 0
    case (op)
        op_ld_b:  return {{24{sh[7]}}, sh[7:0]};
        op_ld_bu: return {24'h0, sh[7:0]};
        op_ld_h:  return {{16{sh[15]}}, sh[15:0]};
        op_ld_hu: return {16'h0, sh[15:0]};
        default:  return sh;
    endcase
endfunction

task automatic ref_store(input mem_op_t op, input word_t addr, input word_t data);
    if (op == op_st_b) ref_mem[addr[7:2]][8*addr[1:0] +: 8] = data[7:0];
    else if (op == op_st_h) ref_mem[addr[7:2]][16*addr[1] +: 16] = data[15:0];
    else ref_mem[addr[7:2]] = data;
endtask

// predict the retire, then hand the op to ex; retires low marks an op that a flush drops
task automatic issue_op(input mem_op_t op, input reg_idx_t rd, input word_t base,
                        input word_t offset, input word_t rkd, input logic retires);
    word_t   addr;
    retire_t e;
    logic    bad;
    logic    load;
    addr = base + offset;
    load = (op == op_ld_b) || (op == op_ld_h) || (op == op_ld_w)
        || (op == op_ld_bu) || (op == op_ld_hu);
    bad  = ((op == op_ld_h || op == op_ld_hu || op == op_st_h) && addr[0])
        || ((op == op_ld_w || op == op_st_w) && addr[1:0] != 2'b00);
    e = '{pc: next_pc, rf_we: 1'b0, rd: rd, rf_wdata: '0, csr_we: 1'b0,
          csr_num: offset[13:0], csr_wdata: rkd, excep: bad,
          ecode: bad ? ecode_ale : ecode_none, badv: addr};
    if (retires) begin
        if (bad) begin
            flush_q.push_back(excep_entry);
        end else if (op == op_csrwr) begin
            e.csr_we = 1'b1;
            if (offset[13:0] == csr_crmd || offset[13:0] == csr_asid
                || offset[13:0] == csr_dmw0 || offset[13:0] == csr_dmw1) begin
                flush_q.push_back(next_pc + 32'd4);
            end
        end else if (load) begin
            e.rf_we    = 1'b1;
            e.rf_wdata = ref_load(op, addr);
        end else begin
            ref_store(op, addr, rkd);
        end
        exp_q.push_back(e);
    end
    @(negedge clk);
    in_valid  = 1'b1;
    in_pc     = next_pc;
    in_op     = op;
    in_rd     = rd;
    in_base   = base;
    in_offset = offset;
    in_rkd    = rkd;
    #1;
    while (!in_allowin) begin
        @(negedge clk);
        #1;
    end
    next_pc = next_pc + 32'd4;
endtask

// stop issuing and wait for every predicted retire and flush
task automatic drain();
    @(negedge clk);
    in_valid = 1'b0;
    while (exp_q.size() != 0 || flush_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
endtask

task automatic test_store_load();
    issue_op(op_st_w, 5'd3, 32'h40, 32'h0, 32'h1234_5678, 1'b1);
    issue_op(op_ld_w, 5'd4, 32'h30, 32'h10, 32'h0, 1'b1);
    drain();
endtask

task automatic test_sub_word_loads();
    issue_op(op_st_w, 5'd1, 32'h80, 32'h0, 32'h8a7f_c301, 1'b1);
    for (int lo = 0; lo < 4; lo++) begin
        issue_op(op_ld_b, 5'd6, 32'h80, 32'(lo), 32'h0, 1'b1);
        issue_op(op_ld_bu, 5'd7, 32'h80, 32'(lo), 32'h0, 1'b1);
    end
    for (int lo = 0; lo < 4; lo += 2) begin
        issue_op(op_ld_h, 5'd8, 32'h80, 32'(lo), 32'h0, 1'b1);
        issue_op(op_ld_hu, 5'd9, 32'h80, 32'(lo), 32'h0, 1'b1);
    end
    issue_op(op_st_w, 5'd1, 32'h84, 32'h0, 32'h0, 1'b1);
    issue_op(op_st_b, 5'd1, 32'h84, 32'h1, 32'h0000_00f0, 1'b1);
    issue_op(op_st_h, 5'd1, 32'h84, 32'h2, 32'h0000_9001, 1'b1);
    issue_op(op_ld_w, 5'd10, 32'h84, 32'h0, 32'h0, 1'b1);
    drain();
endtask

task automatic test_misaligned();
    issue_op(op_ld_w, 5'd5, 32'h40, 32'h2, 32'h0, 1'b1);
    issue_op(op_st_w, 5'd6, 32'h48, 32'h0, 32'hdead_beef, 1'b0);   // flushed
    drain();
    issue_op(op_st_h, 5'd7, 32'h48, 32'h1, 32'h0000_ffff, 1'b1);
    issue_op(op_ld_b, 5'd11, 32'h48, 32'h0, 32'h0, 1'b0);
    drain();
    issue_op(op_ld_w, 5'd8, 32'h48, 32'h0, 32'h0, 1'b1);   // neither store landed
    drain();
endtask

task automatic test_csr_write();
    issue_op(op_csrwr, 5'd0, 32'h0, {18'h0, csr_asid}, 32'h0000_005a, 1'b1);
    issue_op(op_ld_w, 5'd12, 32'h40, 32'h0, 32'h0, 1'b0);
    drain();
    issue_op(op_csrwr, 5'd0, 32'h0, 32'h6, 32'h0000_1234, 1'b1);   // no refetch
    issue_op(op_ld_w, 5'd9, 32'h40, 32'h0, 32'h0, 1'b1);
    drain();
endtask

task automatic test_random_stream();
    logic [31:0] r;
    mem_op_t     op;
    logic [1:0]  lo;
    word_t       addr;
    word_t       offset;
    for (int n = 0; n < 30; n++) begin
        r = $random(seed);
        case (r[2:0])
            3'd0: op = op_ld_b;
            3'd1: op = op_ld_h;
            3'd2: op = op_ld_w;
            3'd3: op = op_ld_bu;
            3'd4: op = op_ld_hu;
            3'd5: op = op_st_b;
            3'd6: op = op_st_h;
            default: op = op_st_w;
        endcase
        if (op == op_ld_b || op == op_ld_bu || op == op_st_b) lo = r[4:3];
        else if (op == op_ld_w || op == op_st_w) lo = 2'b00;
        else lo = {r[4], 1'b0};
        addr   = {24'h0, r[10:5], lo};
        offset = {28'h0, r[14:11]};
        issue_op(op, r[19:15], addr - offset, offset, $random(seed), 1'b1);
    end
    drain();
endtask

//--- verif/tb_mem_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_pipe
    import pipe_pkg::*, isa_pkg::*;
();

    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int total_ops    = 58;   // ops issued over all tests
    localparam int max_cycles   = 40 * total_ops + 2 * reset_cycles;

    typedef struct packed {
        word_t    pc;
        logic     rf_we;
        reg_idx_t rd;
        word_t    rf_wdata;
        logic     csr_we;
        csr_num_t csr_num;
        word_t    csr_wdata;
        logic     excep;
        ecode_t   ecode;
        word_t    badv;
    } retire_t;

    logic       clk;
    logic       resetn;
    logic       in_valid;
    logic       in_allowin;
    word_t      in_pc;
    mem_op_t    in_op;
    reg_idx_t   in_rd;
    word_t      in_base;
    word_t      in_offset;
    word_t      in_rkd;
    logic       data_sram_req;
    logic       data_sram_wr;
    logic [3:0] data_sram_wstrb;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    logic       data_sram_data_ok;
    word_t      data_sram_rdata;
    logic       flush;
    word_t      flush_pc;
    logic       retire_valid;
    word_t      retire_pc;
    logic       retire_rf_we;
    reg_idx_t   retire_rd;
    word_t      retire_rf_wdata;
    logic       retire_csr_we;
    csr_num_t   retire_csr_num;
    word_t      retire_csr_wdata;
    logic       retire_excep;
    ecode_t     retire_ecode;
    word_t      retire_badv;

    word_t   sram [64];      // memory behind the DUT
    word_t   ref_mem [64];   // predicted memory contents
    retire_t exp_q[$];
    word_t   flush_q[$];
    integer  seed = 28;
    int      cycles;
    word_t   next_pc;

    mem_pipe_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    function automatic word_t fill_word(input logic [5:0] a);
        return {4'h5, a, 2'b10, ~a, a, 2'b01, ~a};   // differs per word with mixed signs
    endfunction

    // sram model with one outstanding request and data_ok 1 to 4 cycles later
    initial begin : sram_model
        logic       pend;
        int         lat;
        word_t      rd_buf;
        logic [5:0] idx;
        data_sram_data_ok = 1'b0;
        data_sram_rdata   = '0;
        pend              = 1'b0;
        lat               = 0;
        rd_buf            = '0;
        for (int i = 0; i < 64; i++) sram[i] = fill_word(i[5:0]);
        forever begin
            @(negedge clk);
            if (!resetn) begin
                pend              = 1'b0;
                data_sram_data_ok = 1'b0;
            end else begin
                if (pend && lat == 1) begin
                    data_sram_data_ok = 1'b1;
                    data_sram_rdata   = rd_buf;
                    pend              = 1'b0;
                end else begin
                    data_sram_data_ok = 1'b0;
                    if (pend) lat = lat - 1;
                end
                #1;   // let req settle after data_ok
                if (data_sram_req) begin
                    if (pend) fail_now("Error: SRAM request while a response is outstanding");
                    if (data_sram_addr[31:8] != 24'h0) begin
                        fail_now("Error: SRAM address out of range");
                    end
                    pend = 1'b1;
                    lat  = 1 + ($random(seed) & 3);
                    idx  = data_sram_addr[7:2];
                    if (data_sram_wr) begin
                        for (int b = 0; b < 4; b++) begin
                            if (data_sram_wstrb[b]) begin
                                sram[idx][8*b +: 8] = data_sram_wdata[8*b +: 8];
                            end
                        end
                    end else begin
                        rd_buf = sram[idx];
                    end
                end
            end
        end
    end

    // retire and flush monitor
    initial begin : monitor
        retire_t e;
        forever begin
            @(negedge clk);
            if (resetn && retire_valid) begin
                if (exp_q.size() == 0) begin
                    fail_now("Error: an instruction retired that was not expected");
                end else begin
                    e = exp_q.pop_front();
                    check_eq("retire_pc", retire_pc, e.pc);
                    check_eq("retire_rf_we", 32'(retire_rf_we), 32'(e.rf_we));
                    check_eq("retire_csr_we", 32'(retire_csr_we), 32'(e.csr_we));
                    check_eq("retire_excep", 32'(retire_excep), 32'(e.excep));
                    check_eq("retire_ecode", 32'(retire_ecode), 32'(e.ecode));
                    if (e.rf_we) begin
                        check_eq("retire_rd", 32'(retire_rd), 32'(e.rd));
                        check_eq("retire_rf_wdata", retire_rf_wdata, e.rf_wdata);
                    end
                    if (e.csr_we) begin
                        check_eq("retire_csr_num", 32'(retire_csr_num), 32'(e.csr_num));
                        check_eq("retire_csr_wdata", retire_csr_wdata, e.csr_wdata);
                    end
                    if (e.excep) check_eq("retire_badv", retire_badv, e.badv);
                end
            end
            if (resetn && flush) begin
                if (flush_q.size() == 0) begin
                    fail_now("Error: flush pulse with no exception or refetch expected");
                end else begin
                    check_eq("flush_pc", flush_pc, flush_q.pop_front());
                end
            end
        end
    end

    initial begin : timeout
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > max_cycles) begin
                fail_now($sformatf("Error: timeout, run still going after %0d cycles", cycles));
            end
        end
    end

    `include "tb_mem_tests.svh"

    initial begin
        resetn    = 1'b0;
        in_valid  = 1'b0;
        in_pc     = '0;
        in_op     = op_none;
        in_rd     = '0;
        in_base   = '0;
        in_offset = '0;
        in_rkd    = '0;
        next_pc   = 32'h1c00_0000;
        for (int i = 0; i < 64; i++) ref_mem[i] = fill_word(i[5:0]);
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        #1;
        check_eq("in_allowin after reset", 32'(in_allowin), 32'd1);
        check_eq("retire_valid after reset", 32'(retire_valid), 32'd0);
        check_eq("flush after reset", 32'(flush), 32'd0);
        check_eq("data_sram_req after reset", 32'(data_sram_req), 32'd0);
        test_store_load();
        test_sub_word_loads();
        test_misaligned();
        test_csr_write();
        test_random_stream();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
verilog/pipe_pkg.sv
verilog/isa_pkg.sv
verilog/ex_mem_if.sv
verilog/mem_wb_if.sv
verilog/ex_stage.sv
verilog/mem_stage.sv
verilog/wb_stage.sv
verilog/mem_pipe_top.sv
+incdir+verif
verif/tb_mem_pipe.sv

//--- Makefile
# Verilator build and run for the load/store pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_pipe
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard verilog/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): all.f $(SRCS)
	$(VERILATOR) $(VFLAGS) -f all.f --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

# exit status of the simulator is the pass or fail result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
